//--- bench_defines.svh
`ifndef BENCH_DEFINES_SVH
`define BENCH_DEFINES_SVH

`define BENCH_KEEP_W   64                 // one keep bit per byte lane
`define BENCH_BYTES_W  64                 // byte totals, rx and tx
`define BENCH_CYC_W    64                 // run length in clocks
`define BENCH_CNT_W    32                 // event and stall counters
`define BENCH_RDREQ_W  48                 // summed read-request lengths
`define BENCH_SESS_W   16                 // tcp session id
`define BENCH_LEN_W    16                 // read-request length field

// tx status word layout, error code sits in the top bits
`define BENCH_STS_W    64
`define BENCH_ERR_W    2
`define BENCH_STS_REST_W (`BENCH_STS_W - `BENCH_ERR_W)

`define BENCH_XFER_W   32                 // transfer size in bytes
`define BENCH_WCNT_W   16                 // words per package

`endif

//--- bench_pkg.sv
`include "bench_defines.svh"

package bench_pkg;

	// run configuration from the host, latched on start
	typedef struct packed {
		logic                      is_server;       // server waits for rx before tx
		logic [`BENCH_XFER_W-1:0]  transfer_size;   // bytes each way
		logic [`BENCH_WCNT_W-1:0]  pkg_word_count;  // words per tx package
		logic [`BENCH_SESS_W-1:0]  session_id;      // client session
	} bench_cfg_t;

	// control inputs of the send/receive engine
	typedef struct packed {
		logic                      run_tx;          // one-cycle kick
		logic [`BENCH_SESS_W-1:0]  session_id;
		logic [`BENCH_WCNT_W-1:0]  pkg_word_count;
		logic [`BENCH_XFER_W-1:0]  transfer_size;
	} engine_ctrl_t;

	// one observed data beat, payload not needed
	typedef struct packed {
		logic                      valid;
		logic                      ready;
		logic [`BENCH_KEEP_W-1:0]  keep;            // byte enables, lane 0 first
		logic                      last;
	} axis_obs_t;

	// handshake only, for meta and status streams
	typedef struct packed {
		logic                      valid;
		logic                      ready;
	} beat_obs_t;

	// read-request word, length in the upper half
	typedef struct packed {
		logic [`BENCH_LEN_W-1:0]   length;
		logic [`BENCH_SESS_W-1:0]  session;
	} rd_req_t;

	typedef struct packed {
		logic [`BENCH_ERR_W-1:0]       error;       // zero means good
		logic [`BENCH_STS_REST_W-1:0]  rest;        // session, length etc
	} tx_status_t;

	typedef struct packed {
		logic [`BENCH_CYC_W-1:0]    execution_cycles;
		logic [`BENCH_BYTES_W-1:0]  consumed_bytes;
		logic [`BENCH_BYTES_W-1:0]  produced_bytes;
		logic [`BENCH_RDREQ_W-1:0]  rd_rqst_bytes;
		logic [`BENCH_CNT_W-1:0]    rx_pkt_cnt;
		logic [`BENCH_CNT_W-1:0]    tx_cmd_cnt;
		logic [`BENCH_CNT_W-1:0]    tx_pkg_cnt;
		logic [`BENCH_CNT_W-1:0]    tx_sts_cnt;
		logic [`BENCH_CNT_W-1:0]    tx_sts_good_cnt;
		logic [`BENCH_CNT_W-1:0]    tx_meta_stall;
		logic [`BENCH_CNT_W-1:0]    tx_data_stall;
		logic [`BENCH_CNT_W-1:0]    tx_sts_stall;
	} bench_stats_t;

endpackage

//--- experiment_ctrl.sv
`timescale 1ns/100ps
`include "bench_defines.svh"

module experiment_ctrl (
	input  logic                         ap_clk,
	input  logic                         ap_rst_n,
	input  logic                         ap_start,          // level from host
	input  bench_pkg::bench_cfg_t        cfg,
	input  bench_pkg::beat_obs_t         rx_meta,
	input  logic [`BENCH_SESS_W-1:0]     rx_meta_session,
	input  logic [`BENCH_BYTES_W-1:0]    consumed_bytes,
	input  logic [`BENCH_BYTES_W-1:0]    produced_bytes,
	output logic                         start_pulse,       // clears all counters
	output logic                         ap_idle,
	output logic                         ap_done,
	output bench_pkg::engine_ctrl_t      engine,
	output logic [`BENCH_CYC_W-1:0]      execution_cycles
);

	logic                          start_q;     // ap_start one cycle back
	logic                          running;
	logic                          sent_q;      // run_tx already issued this run
	logic                          run_tx_q;
	logic [`BENCH_SESS_W-1:0]      session_q;
	bench_pkg::bench_cfg_t         cfg_q;       // config held for the run
	logic [`BENCH_BYTES_W-1:0]     xfer_bytes;  // transfer size, widened
	logic                          rx_reached;
	logic                          tx_reached;
	logic                          finish;
	logic                          tx_go;

	always_ff @(posedge ap_clk) begin
		if (!ap_rst_n) begin
			start_q <= 1'b0;
		end else begin
			start_q <= ap_start;
		end
	end

	assign start_pulse = ap_start & ~start_q;   // rising edge only

	always_ff @(posedge ap_clk) begin
		if (start_pulse) begin
			cfg_q <= cfg;
		end
	end

	assign xfer_bytes = {{(`BENCH_BYTES_W - `BENCH_XFER_W){1'b0}}, cfg_q.transfer_size};
	assign rx_reached = consumed_bytes >= xfer_bytes;
	assign tx_reached = produced_bytes >= xfer_bytes;
	assign finish     = running & rx_reached & tx_reached;

	// client kicks tx at once, server after all rx bytes are in
	assign tx_go = running & ~sent_q & (~cfg_q.is_server | rx_reached);

	always_ff @(posedge ap_clk) begin
		if (!ap_rst_n) begin
			ap_idle          <= 1'b1;
			ap_done          <= 1'b0;
			running          <= 1'b0;
			sent_q           <= 1'b0;
			run_tx_q         <= 1'b0;
			session_q        <= '0;
			execution_cycles <= '0;
		end else if (start_pulse) begin
			ap_idle          <= 1'b0;
			ap_done          <= 1'b0;
			running          <= 1'b1;
			sent_q           <= 1'b0;
			run_tx_q         <= 1'b0;
			session_q        <= cfg.is_server ? '0 : cfg.session_id;  // server learns it from rx
			execution_cycles <= '0;
		end else begin
			ap_done  <= finish;             // single pulse, running drops with it
			run_tx_q <= tx_go;              // sent_q blocks a second one
			if (finish) begin
				running <= 1'b0;
			end
			if (ap_done) begin
				ap_idle <= 1'b1;
			end
			if (tx_go) begin
				sent_q <= 1'b1;
			end
			if (running) begin
				execution_cycles <= execution_cycles + 1'b1;
			end
			if (running && cfg_q.is_server && rx_meta.valid && rx_meta.ready) begin
				session_q <= rx_meta_session;   // last accepted wins
			end
		end
	end

	assign engine = '{
		run_tx:         run_tx_q,
		session_id:     session_q,
		pkg_word_count: cfg_q.pkg_word_count,
		transfer_size:  cfg_q.transfer_size
	};

	a_done_single: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
		ap_done |=> !ap_done);

	a_run_tx_single: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
		run_tx_q |=> !run_tx_q);

	// done only closes a run that was actually going
	a_done_after_run: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
		$rose(ap_done) |-> $past(running));

endmodule

//--- keep_byte_counter.sv
`timescale 1ns/100ps
`include "bench_defines.svh"

module keep_byte_counter (
	input  logic                         ap_clk,
	input  logic                         ap_rst_n,
	input  logic                         start_pulse,   // new run, clear total
	input  bench_pkg::axis_obs_t         beat,
	output logic [`BENCH_BYTES_W-1:0]    bytes
);

	localparam int LANE_W = $clog2(`BENCH_KEEP_W + 1);  // 0..64 lanes

	logic                          accept;
	logic [`BENCH_KEEP_W-1:0]      keep_inc;
	logic                          contiguous;
	logic [LANE_W-1:0]             run_len;     // low ones in keep
	logic                          run_on;

	assign accept = beat.valid & beat.ready;

	// walk lanes from bit 0, stop counting at the first hole
	always_comb begin
		run_len = '0;
		run_on  = 1'b1;
		for (int i = 0; i < `BENCH_KEEP_W; i++) begin
			run_on  = run_on & beat.keep[i];
			run_len = run_len + {{(LANE_W - 1){1'b0}}, run_on};
		end
	end

	// 2^n-1 masks only, anything else adds nothing
	assign keep_inc   = beat.keep + 1'b1;
	assign contiguous = (beat.keep & keep_inc) == '0;

	always_ff @(posedge ap_clk) begin
		if (!ap_rst_n) begin
			bytes <= '0;
		end else if (start_pulse) begin
			bytes <= '0;
		end else if (accept && contiguous) begin
			bytes <= bytes + {{(`BENCH_BYTES_W - LANE_W){1'b0}}, run_len};
		end
	end

	// engine never hands over an empty beat
	a_keep_nonzero: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
		accept |-> beat.keep != '0);

endmodule

//--- stream_stats.sv
`timescale 1ns/100ps
`include "bench_defines.svh"

module stream_stats (
	input  logic                         ap_clk,
	input  logic                         ap_rst_n,
	input  logic                         start_pulse,
	input  bench_pkg::axis_obs_t         rx_data,
	input  bench_pkg::axis_obs_t         tx_data,
	input  bench_pkg::beat_obs_t         tx_meta,
	input  bench_pkg::beat_obs_t         tx_status,
	input  bench_pkg::beat_obs_t         rd_req,
	input  bench_pkg::tx_status_t        tx_status_word,
	input  bench_pkg::rd_req_t           rd_req_word,
	output bench_pkg::bench_stats_t      counts        // cycle and byte fields zero
);

	logic                          rx_pkt_ev;
	logic                          tx_pkg_ev;
	logic                          tx_cmd_ev;
	logic                          sts_ev;
	logic                          sts_good_ev;
	logic                          rd_ev;
	logic                          meta_stall_ev;
	logic                          data_stall_ev;
	logic                          sts_stall_ev;

	logic [`BENCH_CNT_W-1:0]       rx_pkt_cnt;
	logic [`BENCH_CNT_W-1:0]       tx_pkg_cnt;
	logic [`BENCH_CNT_W-1:0]       tx_cmd_cnt;
	logic [`BENCH_CNT_W-1:0]       tx_sts_cnt;
	logic [`BENCH_CNT_W-1:0]       tx_sts_good_cnt;
	logic [`BENCH_CNT_W-1:0]       tx_meta_stall;
	logic [`BENCH_CNT_W-1:0]       tx_data_stall;
	logic [`BENCH_CNT_W-1:0]       tx_sts_stall;
	logic [`BENCH_RDREQ_W-1:0]     rd_rqst_bytes;

	// accepted beats
	assign rx_pkt_ev   = rx_data.valid & rx_data.ready & rx_data.last;  // end of rx packet
	assign tx_pkg_ev   = tx_data.valid & tx_data.ready & tx_data.last;
	assign tx_cmd_ev   = tx_meta.valid & tx_meta.ready;                 // one per tx command
	assign sts_ev      = tx_status.valid & tx_status.ready;
	assign sts_good_ev = sts_ev & (tx_status_word.error == '0);
	assign rd_ev       = rd_req.valid & rd_req.ready;

	// engine side back-pressure
	assign meta_stall_ev = tx_meta.valid & ~tx_meta.ready;
	assign data_stall_ev = tx_data.valid & ~tx_data.ready;
	assign sts_stall_ev  = tx_status.valid & ~tx_status.ready;

	always_ff @(posedge ap_clk) begin
		if (!ap_rst_n || start_pulse) begin
			rx_pkt_cnt      <= '0;
			tx_pkg_cnt      <= '0;
			tx_cmd_cnt      <= '0;
			tx_sts_cnt      <= '0;
			tx_sts_good_cnt <= '0;
			tx_meta_stall   <= '0;
			tx_data_stall   <= '0;
			tx_sts_stall    <= '0;
			rd_rqst_bytes   <= '0;
		end else begin
			rx_pkt_cnt      <= rx_pkt_cnt + rx_pkt_ev;
			tx_pkg_cnt      <= tx_pkg_cnt + tx_pkg_ev;
			tx_cmd_cnt      <= tx_cmd_cnt + tx_cmd_ev;
			tx_sts_cnt      <= tx_sts_cnt + sts_ev;
			tx_sts_good_cnt <= tx_sts_good_cnt + sts_good_ev;
			tx_meta_stall   <= tx_meta_stall + meta_stall_ev;
			tx_data_stall   <= tx_data_stall + data_stall_ev;
			tx_sts_stall    <= tx_sts_stall + sts_stall_ev;
			if (rd_ev) begin
				// length only, session field is the engine's business
				rd_rqst_bytes <= rd_rqst_bytes +
					{{(`BENCH_RDREQ_W - `BENCH_LEN_W){1'b0}}, rd_req_word.length};
			end
		end
	end

	always_comb begin
		counts                 = '0;   // top fills cycles and bytes
		counts.rd_rqst_bytes   = rd_rqst_bytes;
		counts.rx_pkt_cnt      = rx_pkt_cnt;
		counts.tx_cmd_cnt      = tx_cmd_cnt;
		counts.tx_pkg_cnt      = tx_pkg_cnt;
		counts.tx_sts_cnt      = tx_sts_cnt;
		counts.tx_sts_good_cnt = tx_sts_good_cnt;
		counts.tx_meta_stall   = tx_meta_stall;
		counts.tx_data_stall   = tx_data_stall;
		counts.tx_sts_stall    = tx_sts_stall;
	end

endmodule

//--- bench_top.sv
`timescale 1ns/100ps
`include "bench_defines.svh"

module bench_top (
	input  logic                         ap_clk,
	input  logic                         ap_rst_n,
	input  logic                         ap_start,
	input  bench_pkg::bench_cfg_t        cfg,
	input  bench_pkg::axis_obs_t         rx_data,         // engine rx data stream
	input  bench_pkg::axis_obs_t         tx_data,         // engine tx data stream
	input  bench_pkg::beat_obs_t         rx_meta,
	input  logic [`BENCH_SESS_W-1:0]     rx_meta_session,
	input  bench_pkg::beat_obs_t         tx_meta,
	input  bench_pkg::beat_obs_t         tx_status,
	input  bench_pkg::tx_status_t        tx_status_word,
	input  bench_pkg::beat_obs_t         rd_req,
	input  bench_pkg::rd_req_t           rd_req_word,
	output logic                         ap_idle,
	output logic                         ap_done,         // also serves as ap_ready
	output bench_pkg::engine_ctrl_t      engine,
	output bench_pkg::bench_stats_t      stats
);

	logic                          start_pulse;
	logic [`BENCH_BYTES_W-1:0]     consumed_bytes;   // rx side total
	logic [`BENCH_BYTES_W-1:0]     produced_bytes;   // tx side total
	logic [`BENCH_CYC_W-1:0]       execution_cycles;
	bench_pkg::bench_stats_t       counts;

	experiment_ctrl u_ctrl (
		.ap_clk           (ap_clk),
		.ap_rst_n         (ap_rst_n),
		.ap_start         (ap_start),
		.cfg              (cfg),
		.rx_meta          (rx_meta),
		.rx_meta_session  (rx_meta_session),
		.consumed_bytes   (consumed_bytes),
		.produced_bytes   (produced_bytes),
		.start_pulse      (start_pulse),
		.ap_idle          (ap_idle),
		.ap_done          (ap_done),
		.engine           (engine),
		.execution_cycles (execution_cycles)
	);

	keep_byte_counter rx_bytes (
		.ap_clk      (ap_clk),
		.ap_rst_n    (ap_rst_n),
		.start_pulse (start_pulse),
		.beat        (rx_data),
		.bytes       (consumed_bytes)
	);

	keep_byte_counter tx_bytes (
		.ap_clk      (ap_clk),
		.ap_rst_n    (ap_rst_n),
		.start_pulse (start_pulse),
		.beat        (tx_data),
		.bytes       (produced_bytes)
	);

	stream_stats u_stats (
		.ap_clk         (ap_clk),
		.ap_rst_n       (ap_rst_n),
		.start_pulse    (start_pulse),
		.rx_data        (rx_data),
		.tx_data        (tx_data),
		.tx_meta        (tx_meta),
		.tx_status      (tx_status),
		.rd_req         (rd_req),
		.tx_status_word (tx_status_word),
		.rd_req_word    (rd_req_word),
		.counts         (counts)
	);

	// merge counter block with the run length and byte totals
	always_comb begin
		stats                  = counts;
		stats.execution_cycles = execution_cycles;
		stats.consumed_bytes   = consumed_bytes;
		stats.produced_bytes   = produced_bytes;
	end

endmodule

//--- tb_bench_checks.svh
`ifndef TB_BENCH_CHECKS_SVH
`define TB_BENCH_CHECKS_SVH

int stats_errors  = 0;   // stats field mismatches
int engine_errors = 0;
int flag_errors   = 0;   // single-bit results
int count_errors  = 0;   // pulse counts seen by the monitor
int other_errors  = 0;   // timeouts, bad trace lines

task automatic compare_field(input string test, input string field,
		input logic [63:0] exp_v, input logic [63:0] act_v);
	if (act_v !== exp_v) begin
		$display("error %s %s: expected %0d actual %0d", test, field, exp_v, act_v);
		stats_errors++;
	end
endtask

task automatic check_stats(input string test, input bench_pkg::bench_stats_t exp_s,
		input bench_pkg::bench_stats_t act_s);
	compare_field(test, "execution_cycles", exp_s.execution_cycles, act_s.execution_cycles);
	compare_field(test, "consumed_bytes", exp_s.consumed_bytes, act_s.consumed_bytes);
	compare_field(test, "produced_bytes", exp_s.produced_bytes, act_s.produced_bytes);
	compare_field(test, "rd_rqst_bytes", exp_s.rd_rqst_bytes, act_s.rd_rqst_bytes);
	compare_field(test, "rx_pkt_cnt", exp_s.rx_pkt_cnt, act_s.rx_pkt_cnt);
	compare_field(test, "tx_cmd_cnt", exp_s.tx_cmd_cnt, act_s.tx_cmd_cnt);
	compare_field(test, "tx_pkg_cnt", exp_s.tx_pkg_cnt, act_s.tx_pkg_cnt);
	compare_field(test, "tx_sts_cnt", exp_s.tx_sts_cnt, act_s.tx_sts_cnt);
	compare_field(test, "tx_sts_good_cnt", exp_s.tx_sts_good_cnt, act_s.tx_sts_good_cnt);
	compare_field(test, "tx_meta_stall", exp_s.tx_meta_stall, act_s.tx_meta_stall);
	compare_field(test, "tx_data_stall", exp_s.tx_data_stall, act_s.tx_data_stall);
	compare_field(test, "tx_sts_stall", exp_s.tx_sts_stall, act_s.tx_sts_stall);
endtask

task automatic check_engine(input string test, input bench_pkg::engine_ctrl_t exp_e,
		input bench_pkg::engine_ctrl_t act_e);
	if (act_e !== exp_e) begin   // run_tx, session, words, size packed in that order
		$display("error %s engine: expected %h actual %h", test, exp_e, act_e);
		engine_errors++;
	end
endtask

task automatic check_bit(input string test, input string what,
		input logic exp_b, input logic act_b);
	if (act_b !== exp_b) begin
		$display("error %s %s: expected %0b actual %0b", test, what, exp_b, act_b);
		flag_errors++;
	end
endtask

task automatic check_count(input string test, input string what,
		input int exp_n, input int act_n);
	if (act_n != exp_n) begin
		$display("error %s %s: expected %0d actual %0d", test, what, exp_n, act_n);
		count_errors++;
	end
endtask

`endif

//--- tb_bench_top.sv
`timescale 1ns/100ps
`include "bench_defines.svh"

module tb_bench_top;

	localparam string TRACE_FILE = "bench_trace.txt";
	localparam int    DONE_WAIT  = 64;          // cycles from last beat to done

	logic                        ap_clk;
	logic                        ap_rst_n;
	logic                        ap_start;
	bench_pkg::bench_cfg_t       cfg;
	bench_pkg::axis_obs_t        rx_data;
	bench_pkg::axis_obs_t        tx_data;
	bench_pkg::beat_obs_t        rx_meta;
	logic [`BENCH_SESS_W-1:0]    rx_meta_session;
	bench_pkg::beat_obs_t        tx_meta;
	bench_pkg::beat_obs_t        tx_status;
	bench_pkg::tx_status_t       tx_status_word;
	bench_pkg::beat_obs_t        rd_req;
	bench_pkg::rd_req_t          rd_req_word;
	logic                        ap_idle;
	logic                        ap_done;
	bench_pkg::engine_ctrl_t     engine;
	bench_pkg::bench_stats_t     stats;

	string  test_name  = "reset";
	int     line_total = 0;       // sizes the watchdog
	int     done_cnt   = 0;
	int     run_tx_cnt = 0;

	`include "tb_bench_checks.svh"

	bench_top dut (
		.ap_clk          (ap_clk),
		.ap_rst_n        (ap_rst_n),
		.ap_start        (ap_start),
		.cfg             (cfg),
		.rx_data         (rx_data),
		.tx_data         (tx_data),
		.rx_meta         (rx_meta),
		.rx_meta_session (rx_meta_session),
		.tx_meta         (tx_meta),
		.tx_status       (tx_status),
		.tx_status_word  (tx_status_word),
		.rd_req          (rd_req),
		.rd_req_word     (rd_req_word),
		.ap_idle         (ap_idle),
		.ap_done         (ap_done),
		.engine          (engine),
		.stats           (stats)
	);

	initial begin
		ap_clk = 1'b0;
		forever #5 ap_clk = ~ap_clk;             // 10 ns period
	end

	task automatic drive_quiet();
		rx_data         = '0;
		tx_data         = '0;
		rx_meta         = '0;
		rx_meta_session = '0;
		tx_meta         = '0;
		tx_status       = '0;
		tx_status_word  = '0;
		rd_req          = '0;
		rd_req_word     = '0;
	endtask

	task automatic check_line_fields(input string kind, input int got, input int want);
		if (got != want) begin
			$display("trace line '%s' has %0d fields where %0d are needed", kind, got, want);
			other_errors++;
		end
	endtask

	// sampled on the rising edge, values of the cycle just ending
	always @(posedge ap_clk) begin
		if (ap_rst_n) begin
			if (ap_done) begin
				done_cnt++;
			end
			if (engine.run_tx) begin
				run_tx_cnt++;
				if (cfg.is_server) begin   // server must have all rx bytes first
					check_bit(test_name, "run_tx after rx total", 1'b1,
						stats.consumed_bytes >= 64'(cfg.transfer_size));
				end
			end
		end
	end

	initial begin
		int limit;
		wait (line_total > 0);
		limit = 20 * line_total + 100;
		repeat (limit) @(posedge ap_clk);
		$display("watchdog: trace still running after %0d cycles, giving up", limit);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int                       fd;
		int                       n;
		int                       waited;
		int                       done_base;
		int                       tx_base;
		string                    kind;
		string                    text;
		logic [63:0]              col [0:18];
		bench_pkg::bench_stats_t  exp_stats;
		bench_pkg::engine_ctrl_t  exp_engine;

		ap_rst_n  = 1'b0;
		ap_start  = 1'b0;
		cfg       = '0;
		drive_quiet();
		done_base = 0;
		tx_base   = 0;

		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("cannot open trace file %s", TRACE_FILE);
			other_errors++;
		end else begin
			while ($fgets(text, fd) != 0) begin
				line_total++;
			end
			$fclose(fd);
			fd = $fopen(TRACE_FILE, "r");   // back to the first line
		end

		repeat (5) @(posedge ap_clk);
		@(negedge ap_clk);
		ap_rst_n = 1'b1;
		check_bit("reset", "ap_idle", 1'b1, ap_idle);
		check_bit("reset", "ap_done", 1'b0, ap_done);
		check_bit("reset", "run_tx", 1'b0, engine.run_tx);
		check_stats("reset", '0, stats);

		while (fd != 0 && $fscanf(fd, "%s", kind) == 1) begin
			if (kind.substr(0, 0) == "#") begin
				void'($fgets(text, fd));   // column notes
			end else if (kind == "cfg") begin
				n = $fscanf(fd, "%s %h %h %h %h", test_name, col[0], col[1], col[2], col[3]);
				check_line_fields(kind, n, 5);
				@(negedge ap_clk);
				drive_quiet();
				cfg       = '{is_server: col[0][0], transfer_size: col[1][31:0],
					pkg_word_count: col[2][15:0], session_id: col[3][15:0]};
				ap_start  = 1'b1;
				done_base = done_cnt;
				tx_base   = run_tx_cnt;
				@(negedge ap_clk);
				ap_start  = 1'b0;
				check_bit(test_name, "ap_idle in run", 1'b0, ap_idle);
			end else if (kind == "beat") begin
				n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
					col[8], col[9], col[10], col[11], col[12], col[13], col[14],
					col[15], col[16], col[17], col[18]);
				check_line_fields(kind, n, 19);
				@(negedge ap_clk);
				rx_data         = '{valid: col[0][0], ready: col[1][0], keep: col[2],
					last: col[3][0]};
				tx_data         = '{valid: col[4][0], ready: col[5][0], keep: col[6],
					last: col[7][0]};
				rx_meta         = '{valid: col[8][0], ready: col[9][0]};
				rx_meta_session = col[10][15:0];
				tx_meta         = '{valid: col[11][0], ready: col[12][0]};
				tx_status       = '{valid: col[13][0], ready: col[14][0]};
				tx_status_word  = '{error: col[15][1:0], rest: '0};
				rd_req          = '{valid: col[16][0], ready: col[17][0]};
				rd_req_word     = '{length: col[18][15:0], session: '0};
			end else if (kind == "idle") begin
				n = $fscanf(fd, "%h", col[0]);
				check_line_fields(kind, n, 1);
				repeat (col[0]) begin
					@(negedge ap_clk);
					drive_quiet();
				end
			end else if (kind == "expect") begin
				n = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h", test_name,
					col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
					col[8], col[9], col[10], col[11], col[12], col[13]);
				check_line_fields(kind, n, 15);
				@(negedge ap_clk);
				drive_quiet();
				waited = 0;
				while (done_cnt == done_base && waited < DONE_WAIT) begin
					@(negedge ap_clk);
					waited++;
				end
				if (done_cnt == done_base) begin
					$display("%s: ap_done never came within %0d cycles", test_name, DONE_WAIT);
					other_errors++;
				end else begin
					exp_stats                  = '0;
					exp_stats.execution_cycles = col[0];
					exp_stats.consumed_bytes   = col[1];
					exp_stats.produced_bytes   = col[2];
					exp_stats.rd_rqst_bytes    = col[3][47:0];
					exp_stats.rx_pkt_cnt       = col[4][31:0];
					exp_stats.tx_cmd_cnt       = col[5][31:0];
					exp_stats.tx_pkg_cnt       = col[6][31:0];
					exp_stats.tx_sts_cnt       = col[7][31:0];
					exp_stats.tx_sts_good_cnt  = col[8][31:0];
					exp_stats.tx_meta_stall    = col[9][31:0];
					exp_stats.tx_data_stall    = col[10][31:0];
					exp_stats.tx_sts_stall     = col[11][31:0];
					check_stats(test_name, exp_stats, stats);
					exp_engine = '{run_tx: 1'b0, session_id: col[12][15:0],
						pkg_word_count: cfg.pkg_word_count, transfer_size: cfg.transfer_size};
					check_engine(test_name, exp_engine, engine);
					check_bit(test_name, "ap_idle after done", 1'b1, ap_idle);
					check_bit(test_name, "ap_done after pulse", 1'b0, ap_done);  // one cycle wide
					check_count(test_name, "ap_done pulses", 1, done_cnt - done_base);
					check_count(test_name, "run_tx pulses", int'(col[13]), run_tx_cnt - tx_base);
				end
			end else begin
				$display("unknown trace keyword '%s'", kind);
				other_errors++;
			end
		end

		if (fd != 0) begin
			$fclose(fd);
		end
		@(negedge ap_clk);
		$display("errors: stats %0d engine %0d flags %0d counts %0d other %0d",
			stats_errors, engine_errors, flag_errors, count_errors, other_errors);
		if (stats_errors + engine_errors + flag_errors + count_errors + other_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- bench_trace.txt
# cfg name is_server transfer_size pkg_words session | idle cycles | all numbers hex
# beat rx:v r keep last tx:v r keep last rx_meta:v r session tx_meta:v r sts:v r err rd:v r len
# expect name cycles consumed produced rd_bytes rx_pkt tx_cmd tx_pkg sts sts_good
# ... meta_stall data_stall sts_stall session run_tx_pulses
# run 1, client with full, partial and broken masks plus all counter kinds
cfg client_run 0 80 10 0123
beat 1 1 ffffffffffffffff 0 0 0 0000000000000000 0 0 0 0000 1 1 0 0 0 0 0 0000
beat 1 0 ffffffffffffffff 0 1 1 ffffffffffffffff 0 0 0 0000 1 0 0 0 0 1 0 0100
beat 1 1 00000000000000ff 0 1 0 ffffffffffffffff 0 1 1 0bad 0 0 1 1 0 0 0 0000
beat 1 1 00000000000000f0 0 1 1 00000000000000ff 1 0 0 0000 0 0 1 1 2 1 1 0040
beat 1 1 ffffffffffffffff 1 1 1 ffffffffffffffff 1 0 0 0000 0 0 1 0 0 1 1 0100
expect client_run 7 88 88 140 1 1 2 2 1 1 1 1 0123 1
idle 3
# run 2, server learns the session from rx meta and sends after rx is complete
cfg server_run 1 40 8 0777
beat 1 1 000000ffffffffff 0 0 0 0000000000000000 0 1 1 0a01 0 0 0 0 0 0 0 0000
beat 1 1 00000000000000ff 0 0 0 0000000000000000 0 1 0 0bad 1 0 0 0 0 0 0 0000
beat 1 1 000000000000ffff 1 0 0 0000000000000000 0 1 1 0a02 0 0 0 0 0 0 0 0000
idle 2
beat 0 0 0000000000000000 0 1 1 00000000ffffffff 0 0 0 0000 1 1 1 0 0 0 0 0000
beat 0 0 0000000000000000 0 1 1 00000000ffffffff 1 0 0 0000 0 0 1 1 0 1 1 0020
expect server_run 9 40 40 20 1 1 1 1 1 1 0 1 0a02 1
idle 3
# run 3, restart clears every count, odd masks on both streams
cfg restart_client 0 20 4 0042
beat 1 1 0000000000000003 0 1 1 0000000000000007 0 0 0 0000 1 1 0 0 0 0 0 0000
beat 1 1 fffffffffffffffe 0 1 1 0000000000000001 0 0 0 0000 0 0 0 0 0 0 0 0000
beat 1 1 00000000ffff00ff 0 1 0 00000000000000ff 0 0 0 0000 0 0 0 0 0 0 0 0000
beat 1 1 000000003fffffff 1 1 1 000000000fffffff 1 0 0 0000 0 0 1 1 1 1 1 0010
expect restart_client 6 20 20 10 1 1 1 1 0 0 1 0 0042 1

//--- all.f
+incdir+.
bench_pkg.sv
experiment_ctrl.sv
keep_byte_counter.sv
stream_stats.sv
bench_top.sv
tb_bench_top.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only --timing -Wall
TOP       := tb_bench_top
RTL_TOP   := bench_top
FILELIST  := all.f
LOG       := sim.log
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@! grep -q "TEST FAILED" $(LOG)
	@grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
